/* source/dp_cmd_pkg.sv */
package dp_cmd_pkg;

    // ################################################
    // Command packet layout
    // ################################################

    localparam int PACKET_SIZE = 16;
    localparam int OPCODE_W    = 2;

    // One mask bit per replay iteration, so the mask width caps the iteration count
    localparam int REPLAY_ITER_LIMIT = 4;
    localparam int MASK_W            = REPLAY_ITER_LIMIT;
    localparam int PAYLOAD_W         = PACKET_SIZE - OPCODE_W - MASK_W;

    typedef enum logic [OPCODE_W-1:0] {
        op_task    = 2'b00,
        op_replay  = 2'b01,
        op_num_fv  = 2'b10,
        op_weights = 2'b11
    } opcode_t;

    // Opcode on top, then iteration mask, then payload
    typedef struct packed {
        opcode_t              opcode;
        logic [MASK_W-1:0]    iter_mask;
        logic [PAYLOAD_W-1:0] payload;
    } cmd_packet_t;

    // Packet minus its opcode, as the reservation station sees it
    typedef logic [PACKET_SIZE-OPCODE_W-1:0] rs_task_t;

    localparam int NUM_FV_W   = 5; // Counts 0 to 16
    localparam int BOUNDARY_W = 4;

    // ################################################
    // Replay counter sizing
    // ################################################

    function automatic int replay_w(input int max_iter);
        return (max_iter > 1) ? $clog2(max_iter) : 1;
    endfunction

endpackage

/* source/dp_mem_pkg.sv */
package dp_mem_pkg;

    // ################################################
    // Shared memory request bus
    // ################################################

    localparam int MEM_WORD_W = 16;

    typedef logic [MEM_WORD_W-1:0] mem_word_t;

    // Which requester owns the word on the bus
    typedef enum logic {
        src_decoder = 1'b0,
        src_loader  = 1'b1
    } mem_src_t;

endpackage

/* source/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter import dp_mem_pkg::*; #(
    parameter int WORD_W = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_dec,
    input  logic              req_ld,
    input  logic [WORD_W-1:0] data_dec,
    input  logic [WORD_W-1:0] data_ld,
    output logic              grant_dec,
    output logic              grant_ld,
    output logic              mem_valid,
    output logic [WORD_W-1:0] mem_data,
    output mem_src_t          mem_src
);

    mem_src_t last_winner;

    // On a tie the requester that did not win last time goes first
    assign grant_dec = req_dec && (!req_ld || last_winner == src_loader);
    assign grant_ld  = req_ld && (!req_dec || last_winner == src_decoder);

    assign mem_valid = grant_dec || grant_ld;
    assign mem_src   = grant_ld ? src_loader : src_decoder;
    assign mem_data  = grant_ld ? data_ld : data_dec;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_winner <= src_loader; // Decoder wins the first tie
        end else if (mem_valid) begin
            last_winner <= mem_src;
        end
    end

    // Only one requester may own the bus in a cycle
    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(grant_dec && grant_ld));

endmodule

/* source/stream_loader.sv */
`timescale 1ns/1ps

module stream_loader import dp_cmd_pkg::*; import dp_mem_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                stream_begin,
    input  logic [NUM_FV_W-1:0] num_fv,
    input  logic                grant,
    output logic                req,
    output mem_word_t           mem_data,
    output logic                stream_end
);

    localparam int PAD_W = MEM_WORD_W - OPCODE_W - NUM_FV_W;

    logic                active;
    logic [NUM_FV_W-1:0] fv_count;
    logic [NUM_FV_W-1:0] fv_index;
    logic                last_word;

    assign req       = active;
    assign mem_data  = {op_num_fv, {PAD_W{1'b0}}, fv_index}; // Read of vector fv_index
    assign last_word = (fv_index == fv_count - 1'b1);

    // ################################################
    // Stream control
    // ################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            fv_index   <= '0;
            stream_end <= 1'b0;
        end else begin
            stream_end <= 1'b0;
            if (stream_begin) begin
                fv_index   <= '0;
                active     <= (num_fv != '0);
                stream_end <= (num_fv == '0); // Empty stream ends right away
            end else if (active && grant) begin
                fv_index <= fv_index + 1'b1;
                if (last_word) begin
                    active     <= 1'b0;
                    stream_end <= 1'b1;
                end
            end
        end
    end

    // Count is sampled once per stream
    always_ff @(posedge clk) begin
        if (stream_begin) begin
            fv_count <= num_fv;
        end
    end

    // The decoder holds back a new feature count until the previous stream has ended
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        stream_begin |-> !active);

endmodule

/* source/cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder import dp_cmd_pkg::*; import dp_mem_pkg::*; #(
    parameter int MAX_REPLAY_ITER = 4,
    parameter int NUM_PE          = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cmd_valid,
    input  cmd_packet_t                           cmd_packet,
    input  logic                                  rs_empty,
    input  logic [NUM_PE-1:0]                     bank_busy,
    input  logic [NUM_PE-1:0]                     pe_idle,
    input  logic                                  grant,
    input  logic                                  stream_end,
    input  logic                                  vertex_done,
    output logic                                  fifo_stall,
    output logic                                  rs_task_valid,
    output rs_task_t                              rs_task,
    output logic                                  req,
    output mem_word_t                             mem_data,
    output logic                                  cntl_done,
    output logic                                  task_complete,
    output logic                                  stream_begin,
    output logic                                  replay_active,
    output logic [replay_w(MAX_REPLAY_ITER)-1:0]  replay_iter,
    output logic [NUM_FV_W-1:0]                   num_fv,
    output logic [BOUNDARY_W-1:0]                 weights_boundary
);

    localparam int REPLAY_W = replay_w(MAX_REPLAY_ITER);
    localparam logic [REPLAY_W-1:0] LAST_ITER = REPLAY_W'(MAX_REPLAY_ITER - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_grant,
        st_wait_replay,
        st_wait_stream,
        st_wait_task
    } dec_state_t;

    dec_state_t            state;
    dec_state_t            nx_state;
    cmd_packet_t           parked_packet;
    logic                  park_en;
    logic [REPLAY_W-1:0]   nx_replay_iter;
    logic [NUM_FV_W-1:0]   nx_num_fv;
    logic [BOUNDARY_W-1:0] nx_boundary;
    logic                  nx_replay_active;
    logic                  nx_stream_begin;
    logic                  stream_active;
    logic                  stream_done;
    logic                  array_clear;
    logic                  mask_hit;
    logic                  last_iter;

    // Array must be fully drained before a replay goes out
    assign array_clear = !(|bank_busy) && (&pe_idle) && rs_empty;
    assign mask_hit    = cmd_packet.iter_mask[replay_iter];
    assign last_iter   = (replay_iter == LAST_ITER);
    assign stream_done = stream_end || !stream_active;

    assign rs_task  = rs_task_t'({cmd_packet.iter_mask, cmd_packet.payload});
    assign mem_data = (state == st_idle) ? mem_word_t'(cmd_packet) : mem_word_t'(parked_packet);

    // ################################################
    // Next state and outputs
    // ################################################

    always_comb begin
        nx_state         = state;
        nx_replay_iter   = replay_iter;
        nx_num_fv        = num_fv;
        nx_boundary      = weights_boundary;
        nx_replay_active = replay_active;
        nx_stream_begin  = 1'b0;
        park_en          = 1'b0;
        fifo_stall       = 1'b0;
        rs_task_valid    = 1'b0;
        req              = 1'b0;
        cntl_done        = 1'b0;
        task_complete    = 1'b0;
        case (state)
            st_idle: begin
                if (cmd_valid && !replay_active) begin
                    case (cmd_packet.opcode)
                        op_task: begin
                            if (mask_hit) begin
                                rs_task_valid = 1'b1;
                            end else begin
                                // Park in memory, straight away if the bus is free
                                req        = 1'b1;
                                park_en    = 1'b1;
                                fifo_stall = !grant;
                                if (!grant) begin
                                    nx_state = st_wait_grant;
                                end
                            end
                        end
                        op_replay: begin
                            park_en          = 1'b1;
                            fifo_stall       = 1'b1;
                            nx_replay_active = 1'b1;
                            nx_state         = st_wait_replay;
                        end
                        op_num_fv: begin
                            if (stream_active) begin
                                fifo_stall = 1'b1; // Previous stream still running
                            end else begin
                                nx_num_fv       = cmd_packet.payload[NUM_FV_W-1:0];
                                nx_stream_begin = 1'b1;
                            end
                        end
                        op_weights: begin
                            nx_boundary = cmd_packet.payload[BOUNDARY_W-1:0];
                            if (!stream_done) begin
                                fifo_stall = 1'b1;
                                nx_state   = st_wait_stream;
                            end
                        end
                    endcase
                end
            end
            st_wait_grant: begin
                req        = 1'b1;
                fifo_stall = !grant;
                if (grant) begin
                    nx_state = st_idle;
                end
            end
            st_wait_replay: begin
                fifo_stall = 1'b1;
                if (array_clear) begin
                    if (last_iter) begin
                        cntl_done = 1'b1;
                        nx_state  = st_wait_task;
                    end else begin
                        req = 1'b1;
                        if (grant) begin
                            nx_replay_iter = replay_iter + 1'b1;
                            nx_state       = st_wait_stream;
                        end
                    end
                end
            end
            st_wait_stream: begin
                fifo_stall = !stream_done;
                if (stream_done) begin
                    nx_replay_active = 1'b0;
                    nx_state         = st_idle;
                end
            end
            st_wait_task: begin
                fifo_stall = !vertex_done;
                if (vertex_done) begin
                    task_complete    = 1'b1;
                    nx_replay_active = 1'b0;
                    nx_state         = st_idle;
                end
            end
            default: nx_state = st_idle;
        endcase
    end

    // ################################################
    // Registers
    // ################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= st_idle;
            replay_iter      <= '0;
            num_fv           <= '0;
            weights_boundary <= '0;
            replay_active    <= 1'b0;
            stream_begin     <= 1'b0;
            stream_active    <= 1'b0;
        end else begin
            state            <= nx_state;
            replay_iter      <= nx_replay_iter;
            num_fv           <= nx_num_fv;
            weights_boundary <= nx_boundary;
            replay_active    <= nx_replay_active;
            stream_begin     <= nx_stream_begin;
            if (nx_stream_begin) begin
                stream_active <= 1'b1;
            end else if (stream_end) begin
                stream_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (park_en) begin
            parked_packet <= cmd_packet;
        end
    end

    // A parked packet keeps asking until the arbiter takes it
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        (state == st_wait_grant && !grant) |=> req);

endmodule

/* source/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top import dp_cmd_pkg::*; import dp_mem_pkg::*; #(
    parameter int MAX_REPLAY_ITER = 4,
    parameter int NUM_PE          = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  cmd_valid,
    input  cmd_packet_t                           cmd_packet,
    input  logic                                  rs_empty,
    input  logic [NUM_PE-1:0]                     bank_busy,
    input  logic [NUM_PE-1:0]                     pe_idle,
    input  logic                                  vertex_done,
    output logic                                  fifo_stall,
    output logic                                  rs_task_valid,
    output rs_task_t                              rs_task,
    output logic                                  cntl_done,
    output logic                                  task_complete,
    output logic                                  replay_active,
    output logic [replay_w(MAX_REPLAY_ITER)-1:0]  replay_iter,
    output logic [NUM_FV_W-1:0]                   num_fv,
    output logic [BOUNDARY_W-1:0]                 weights_boundary,
    output logic                                  mem_valid,
    output mem_word_t                             mem_data,
    output mem_src_t                              mem_src,
    output logic                                  stream_end
);

    logic      req_dec;
    logic      grant_dec;
    mem_word_t data_dec;
    logic      req_ld;
    logic      grant_ld;
    mem_word_t data_ld;
    logic      stream_begin;

    cmd_decoder #(
        .MAX_REPLAY_ITER (MAX_REPLAY_ITER),
        .NUM_PE          (NUM_PE)
    ) u_cmd_decoder (
        .clk              (clk),
        .reset            (reset),
        .cmd_valid        (cmd_valid),
        .cmd_packet       (cmd_packet),
        .rs_empty         (rs_empty),
        .bank_busy        (bank_busy),
        .pe_idle          (pe_idle),
        .grant            (grant_dec),
        .stream_end       (stream_end),
        .vertex_done      (vertex_done),
        .fifo_stall       (fifo_stall),
        .rs_task_valid    (rs_task_valid),
        .rs_task          (rs_task),
        .req              (req_dec),
        .mem_data         (data_dec),
        .cntl_done        (cntl_done),
        .task_complete    (task_complete),
        .stream_begin     (stream_begin),
        .replay_active    (replay_active),
        .replay_iter      (replay_iter),
        .num_fv           (num_fv),
        .weights_boundary (weights_boundary)
    );

    stream_loader u_stream_loader (
        .clk          (clk),
        .reset        (reset),
        .stream_begin (stream_begin),
        .num_fv       (num_fv),
        .grant        (grant_ld),
        .req          (req_ld),
        .mem_data     (data_ld),
        .stream_end   (stream_end)
    );

    // Both requesters share the one memory port
    mem_arbiter #(
        .WORD_W (MEM_WORD_W)
    ) u_mem_arbiter (
        .clk       (clk),
        .reset     (reset),
        .req_dec   (req_dec),
        .req_ld    (req_ld),
        .data_dec  (data_dec),
        .data_ld   (data_ld),
        .grant_dec (grant_dec),
        .grant_ld  (grant_ld),
        .mem_valid (mem_valid),
        .mem_data  (mem_data),
        .mem_src   (mem_src)
    );

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter realtime PERIOD = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk; // 50 percent duty cycle
        end
    end

endmodule

/* verif/dispatch_tb.sv */
`timescale 1ns/1ps

module dispatch_tb import dp_cmd_pkg::*, dp_mem_pkg::*; ();

    localparam int MAX_ITER   = 4;
    localparam int NUM_PE     = 4;
    localparam int NUM_ROWS   = 12;
    localparam int ROW_CYCLES = 64;

    localparam int K_HIT     = 0;
    localparam int K_PARK    = 1;
    localparam int K_NUMFV   = 2;
    localparam int K_WEIGHTS = 3;
    localparam int K_REPLAY  = 4;
    localparam int K_LAST    = 5;

    // Task packet with an all-zero mask, so it always parks
    localparam mem_word_t COMPETE_PKT = 16'h0055;

    typedef struct {
        int          kind;
        cmd_packet_t pkt;
        int          aux;      // Stream length for the weights row
        mem_word_t   exp_word; // Task to the station or word on the bus
        int          exp_iter;
        int          exp_fv;
        int          exp_bnd;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 cmd_valid;
    cmd_packet_t          cmd_packet;
    logic                 rs_empty;
    logic [NUM_PE-1:0]    bank_busy;
    logic [NUM_PE-1:0]    pe_idle;
    logic                 vertex_done;
    logic                 fifo_stall;
    logic                 rs_task_valid;
    rs_task_t             rs_task;
    logic                 cntl_done;
    logic                 task_complete;
    logic                 replay_active;
    logic [1:0]           replay_iter;
    logic [NUM_FV_W-1:0]  num_fv;
    logic [BOUNDARY_W-1:0] weights_boundary;
    logic                 mem_valid;
    mem_word_t            mem_data;
    mem_src_t             mem_src;
    logic                 stream_end;

    row_t      rows [NUM_ROWS];
    int        seed = 32'h1f38b228;
    mem_word_t word_q[$];
    mem_src_t  src_q[$];
    rs_task_t  rs_q[$];
    int        end_cnt;
    int        done_cnt;
    int        tc_cnt;
    int        busy_words;
    int        early_tc;
    int        active_cycles;
    logic      last_stall;
    logic      last_end;
    int        bank_left;
    int        idle_left;
    int        empty_left;
    int        vtx_left;

    tb_clock #(.PERIOD(4.0)) u_tb_clock (.clk(clk));

    dispatch_top #(
        .MAX_REPLAY_ITER (MAX_ITER),
        .NUM_PE          (NUM_PE)
    ) u_dispatch_top (
        .clk              (clk),
        .reset            (reset),
        .cmd_valid        (cmd_valid),
        .cmd_packet       (cmd_packet),
        .rs_empty         (rs_empty),
        .bank_busy        (bank_busy),
        .pe_idle          (pe_idle),
        .vertex_done      (vertex_done),
        .fifo_stall       (fifo_stall),
        .rs_task_valid    (rs_task_valid),
        .rs_task          (rs_task),
        .cntl_done        (cntl_done),
        .task_complete    (task_complete),
        .replay_active    (replay_active),
        .replay_iter      (replay_iter),
        .num_fv           (num_fv),
        .weights_boundary (weights_boundary),
        .mem_valid        (mem_valid),
        .mem_data         (mem_data),
        .mem_src          (mem_src),
        .stream_end       (stream_end)
    );

    // ################################################
    // Checks
    // ################################################

    task automatic fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_task(input rs_task_t got, input rs_task_t exp);
        if (got !== exp) fail($sformatf("rs_task %h, expected %h", got, exp));
    endtask

    task automatic check_mem(input mem_word_t got, input mem_src_t got_src,
                             input mem_word_t exp, input mem_src_t exp_src);
        if (got !== exp || got_src !== exp_src) begin
            fail($sformatf("mem word %h from %s, expected %h from %s",
                           got, got_src.name(), exp, exp_src.name()));
        end
    endtask

    task automatic check_level(input logic [NUM_FV_W-1:0] got_fv,
                               input logic [NUM_FV_W-1:0] exp_fv,
                               input logic [BOUNDARY_W-1:0] got_bnd,
                               input logic [BOUNDARY_W-1:0] exp_bnd);
        if (got_fv !== exp_fv || got_bnd !== exp_bnd) begin
            fail($sformatf("num_fv %0d boundary %0d, expected %0d and %0d",
                           got_fv, got_bnd, exp_fv, exp_bnd));
        end
    endtask

    task automatic check_pulse(input int got_done, input int exp_done,
                               input int got_tc, input int exp_tc);
        if (got_done != exp_done || got_tc != exp_tc) begin
            fail($sformatf("%0d cntl_done and %0d task_complete pulses, expected %0d and %0d",
                           got_done, got_tc, exp_done, exp_tc));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) fail($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    // ################################################
    // Cycle driver
    // ################################################

    // Sample at the falling edge, then step to just after the next rising edge
    task automatic tick();
        @(negedge clk);
        last_stall = fifo_stall;
        last_end   = stream_end;
        if (mem_valid) begin
            word_q.push_back(mem_data);
            src_q.push_back(mem_src);
            if (mem_src == src_decoder && ((|bank_busy) || !(&pe_idle) || !rs_empty))
                busy_words++;
        end
        if (rs_task_valid) rs_q.push_back(rs_task);
        if (stream_end) end_cnt++;
        if (cntl_done) done_cnt++;
        if (task_complete) tc_cnt++;
        if (task_complete && !vertex_done) early_tc++;
        if (replay_active) active_cycles++;
        @(posedge clk);
        #1;
        // Array status releases one condition at a time
        if (bank_left > 0) begin
            bank_left--;
            if (bank_left == 0) bank_busy = '0;
        end
        if (idle_left > 0) begin
            idle_left--;
            if (idle_left == 0) pe_idle = '1;
        end
        if (empty_left > 0) begin
            empty_left--;
            if (empty_left == 0) rs_empty = 1'b1;
        end
        vertex_done = 1'b0;
        if (vtx_left > 0) begin
            vtx_left--;
            if (vtx_left == 0) vertex_done = 1'b1;
        end
    endtask

    // The FIFO repeats the packet for as long as the stall is high
    task automatic send_packet(input cmd_packet_t pkt, output int stalls);
        stalls     = 0;
        cmd_valid  = 1'b1;
        cmd_packet = pkt;
        tick();
        while (last_stall) begin
            stalls++;
            tick();
        end
        cmd_valid = 1'b0;
    endtask

    task automatic clear_record();
        word_q.delete();
        src_q.delete();
        rs_q.delete();
        end_cnt       = 0;
        done_cnt      = 0;
        tc_cnt        = 0;
        busy_words    = 0;
        early_tc      = 0;
        active_cycles = 0;
    endtask

    // Loader words must be feature reads 0 to n_ld-1 in order
    task automatic scan_words(input int n_ld, input int n_dec, input mem_word_t dec_word,
                              output int ld_before_dec);
        int k;
        int d;
        k = 0;
        d = 0;
        ld_before_dec = 0;
        foreach (word_q[i]) begin
            if (src_q[i] == src_loader) begin
                check_mem(word_q[i], src_q[i], mem_word_t'({2'b10, 14'(k)}), src_loader);
                k++;
                if (d == 0) ld_before_dec++;
            end else begin
                check_mem(word_q[i], src_q[i], dec_word, src_decoder);
                d++;
            end
        end
        check_count(k, n_ld, "loader word count");
        check_count(d, n_dec, "decoder word count");
    endtask

    task automatic add_row(input int idx, input int kind, input mem_word_t pkt, input int aux,
                           input mem_word_t exp_word, input int exp_iter,
                           input int exp_fv, input int exp_bnd);
        rows[idx] = '{kind, cmd_packet_t'(pkt), aux, exp_word, exp_iter, exp_fv, exp_bnd};
    endtask

    // ################################################
    // Stimulus
    // ################################################

    initial begin
        int stalls;
        int ld_before;
        row_t r;
        reset       = 1'b1;
        cmd_valid   = 1'b0;
        cmd_packet  = '0;
        rs_empty    = 1'b1;
        bank_busy   = '0;
        pe_idle     = '1;
        vertex_done = 1'b0;
        bank_left   = 0;
        idle_left   = 0;
        empty_left  = 0;
        vtx_left    = 0;
        clear_record();

        add_row(0,  K_HIT,     16'h06a5, 0, 16'h06a5, 0, 0,  0);
        add_row(1,  K_PARK,    16'h393c, 0, 16'h393c, 0, 0,  0);
        add_row(2,  K_NUMFV,   16'h8000, 0, 16'h0000, 0, 0,  0);
        add_row(3,  K_NUMFV,   16'h8001, 0, 16'h0000, 0, 1,  0);
        add_row(4,  K_NUMFV,   16'h8010, 0, 16'h0000, 0, 16, 0);
        add_row(5,  K_WEIGHTS, 16'hc009, 6, 16'h0000, 0, 6,  9);
        add_row(6,  K_REPLAY,  16'h4003, 0, 16'h4003, 1, 6,  9);
        add_row(7,  K_HIT,     16'h08f0, 0, 16'h08f0, 1, 6,  9);
        add_row(8,  K_REPLAY,  16'h4011, 0, 16'h4011, 2, 6,  9);
        add_row(9,  K_REPLAY,  16'h4022, 0, 16'h4022, 3, 6,  9);
        add_row(10, K_PARK,    16'h1fff, 0, 16'h1fff, 3, 6,  9);
        add_row(11, K_LAST,    16'h4033, 0, 16'h0000, 3, 6,  9);

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        tick();

        for (int i = 0; i < NUM_ROWS; i++) begin
            r = rows[i];
            clear_record();
            if (r.kind == K_REPLAY || r.kind == K_LAST) begin
                bank_left  = 1 + ($unsigned($random(seed)) % 6);
                idle_left  = 1 + ($unsigned($random(seed)) % 6);
                empty_left = 1 + ($unsigned($random(seed)) % 6);
                bank_busy  = 4'b0100;
                pe_idle    = 4'b1101;
                rs_empty   = 1'b0;
                if (r.kind == K_LAST) vtx_left = 10 + ($unsigned($random(seed)) % 4);
            end
            case (r.kind)
                K_HIT: begin
                    send_packet(r.pkt, stalls);
                    check_count(stalls, 0, "stall cycles for a mask hit");
                    check_count(rs_q.size(), 1, "rs_task strobes");
                    check_task(rs_q[0], rs_task_t'(r.exp_word));
                end
                K_PARK: begin
                    send_packet(r.pkt, stalls);
                    repeat (2) tick();
                    check_count(rs_q.size(), 0, "rs_task strobes");
                    scan_words(0, 1, r.exp_word, ld_before);
                end
                K_NUMFV: begin
                    send_packet(r.pkt, stalls);
                    check_level(num_fv, NUM_FV_W'(r.exp_fv), weights_boundary, '0);
                    while (end_cnt == 0) tick();
                    repeat (2) tick();
                    check_count(end_cnt, 1, "stream_end pulses");
                    scan_words(r.exp_fv, 0, '0, ld_before);
                end
                K_WEIGHTS: begin
                    send_packet(cmd_packet_t'({op_num_fv, 4'h0, 10'(r.aux)}), stalls);
                    tick(); // Loader starts requesting after this cycle
                    // Loader took the last grant, so the decoder wins this tie
                    send_packet(cmd_packet_t'(COMPETE_PKT), stalls);
                    check_count(stalls, 0, "stall cycles for the first competing task");
                    // Decoder won the last tie, so it waits one cycle for the loader
                    send_packet(cmd_packet_t'(COMPETE_PKT), stalls);
                    check_count(stalls, 1, "stall cycles for the second competing task");
                    send_packet(r.pkt, stalls);
                    check_count(int'(last_end), 1, "stream_end in the stall release cycle");
                    check_level(num_fv, NUM_FV_W'(r.exp_fv),
                                weights_boundary, BOUNDARY_W'(r.exp_bnd));
                    repeat (2) tick();
                    check_count(end_cnt, 1, "stream_end pulses");
                    scan_words(r.aux, 2, COMPETE_PKT, ld_before);
                    check_count(ld_before, 0, "loader words before the first decoder word");
                end
                K_REPLAY: begin
                    send_packet(r.pkt, stalls);
                    repeat (2) tick();
                    check_count(busy_words, 0, "replay words while the array was busy");
                    scan_words(0, 1, r.exp_word, ld_before);
                end
                default: begin
                    send_packet(r.pkt, stalls);
                    repeat (2) tick();
                    check_count(word_q.size(), 0, "memory words on the last replay");
                    check_count(early_tc, 0, "task_complete pulses before vertex_done");
                end
            endcase
            check_pulse(done_cnt, (r.kind == K_LAST) ? 1 : 0, tc_cnt, (r.kind == K_LAST) ? 1 : 0);
            check_count(int'(replay_iter), r.exp_iter, "replay_iter");
            check_count(int'(active_cycles > 0), int'(r.kind == K_REPLAY || r.kind == K_LAST),
                        "replay_active seen during the row");
            check_count(int'(replay_active), 0, "replay_active at the end of the row");
        end

        $display("Finished with no errors");
        $finish;
    end

    // ################################################
    // Watchdog
    // ################################################

    initial begin
        repeat (NUM_ROWS * ROW_CYCLES + 10) @(posedge clk);
        $display("Timeout: the run hung waiting for the DUT");
        $display("Finished with errors");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* graph_dp.f */
source/dp_cmd_pkg.sv
source/dp_mem_pkg.sv
source/mem_arbiter.sv
source/stream_loader.sv
source/cmd_decoder.sv
source/dispatch_top.sv
verif/tb_clock.sv
verif/dispatch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module dispatch_tb \
    -f graph_dp.f -o dispatch_sim \
    && ./obj_dir/dispatch_sim | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
